// ==== hw/rubik_pkg.sv ====
// shared widths, register map, mode enum and bus structs, imported by every tile transposer block
`default_nettype none

package rubik_pkg;

  // ================================================
  // geometry
  // ================================================
  localparam int LANES  = 4;               // tile edge, words per tile and elements per word
  localparam int ELEM_W = 8;
  localparam int WORD_W = LANES * ELEM_W;
  localparam int ADDR_W = 16;              // memory word address
  localparam int IDX_W  = 2;               // word index within a tile
  localparam int TILE_W = 8;

  // ================================================
  // register map
  // ================================================
  localparam int REG_ADDR_W = 3;
  localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 3'd0;
  localparam logic [REG_ADDR_W-1:0] REG_SRC    = 3'd1;
  localparam logic [REG_ADDR_W-1:0] REG_DST    = 3'd2;
  localparam logic [REG_ADDR_W-1:0] REG_TILES  = 3'd3;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS = 3'd4;

  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_MODE_BIT   = 1;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;  // write 1 to clear

  typedef enum logic {
    MODE_PASS      = 1'b0,
    MODE_TRANSPOSE = 1'b1
  } rubik_mode_e;

  typedef struct packed {
    rubik_mode_e       mode;
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [TILE_W-1:0] tiles;
  } rubik_cfg_t;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [REG_ADDR_W-1:0] adr;
    logic [WORD_W-1:0]     dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [WORD_W-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } rd_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
  } wr_req_t;

  typedef struct packed {
    logic              valid;
    logic [IDX_W-1:0]  idx;   // word position in the tile
    logic [WORD_W-1:0] data;
  } lane_in_t;

endpackage

`default_nettype wire

// ==== hw/rubik_regfile.sv ====
// Wishbone classic register block with job setup, start pulse, sticky done and interrupt
`default_nettype none
`timescale 1ns/10ps

module rubik_regfile import rubik_pkg::*; (
  input  wire logic    nvdla_core_clk,
  input  wire logic    rst_n,
  input  wire wb_req_t wb_req,
  output wb_rsp_t      wb_rsp,
  input  wire logic    busy,
  input  wire logic    done,
  output rubik_cfg_t   cfg,
  output logic         start,
  output logic         irq
);

  logic              ack_q;
  logic [WORD_W-1:0] rdata_q;
  logic [WORD_W-1:0] rd_mux;
  logic              done_q;
  logic              req_hit;
  logic              wr_fire;

  assign req_hit = wb_req.cyc && wb_req.stb;
  assign wr_fire = req_hit && wb_req.we && ack_q;  // write commits with the ack

  // ================================================
  // bus handshake and read path
  // ================================================
  always_comb begin
    rd_mux = '0;
    case (wb_req.adr)
      REG_CTRL:   rd_mux[CTRL_MODE_BIT] = cfg.mode;
      REG_SRC:    rd_mux[ADDR_W-1:0] = cfg.src;
      REG_DST:    rd_mux[ADDR_W-1:0] = cfg.dst;
      REG_TILES:  rd_mux[TILE_W-1:0] = cfg.tiles;
      REG_STATUS: begin
        rd_mux[STATUS_BUSY_BIT] = busy;
        rd_mux[STATUS_DONE_BIT] = done_q;
      end
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_hit && !ack_q;  // single cycle ack
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (req_hit && !ack_q && !wb_req.we) begin
      rdata_q <= rd_mux;
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rdata_q};

  // ================================================
  // job registers and completion
  // ================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      cfg    <= '{mode: MODE_PASS, src: '0, dst: '0, tiles: '0};
      start  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      start <= wr_fire && (wb_req.adr == REG_CTRL) && wb_req.dat[CTRL_START_BIT]
               && !busy && !start;
      if (wr_fire) begin
        case (wb_req.adr)
          REG_CTRL:  cfg.mode  <= rubik_mode_e'(wb_req.dat[CTRL_MODE_BIT]);
          REG_SRC:   cfg.src   <= wb_req.dat[ADDR_W-1:0];
          REG_DST:   cfg.dst   <= wb_req.dat[ADDR_W-1:0];
          REG_TILES: cfg.tiles <= wb_req.dat[TILE_W-1:0];
          default:   ;
        endcase
      end
      if (wr_fire && (wb_req.adr == REG_STATUS) && wb_req.dat[STATUS_DONE_BIT]) begin
        done_q <= 1'b0;  // w1c
      end
      if (done) begin
        done_q <= 1'b1;  // set wins over clear
      end
    end
  end

  assign irq = done_q;

endmodule

`default_nettype wire

// ==== hw/rubik_seq_gen.sv ====
// job sequencer issuing tile read requests and tracking finished tiles until the job ends
`default_nettype none
`timescale 1ns/10ps

module rubik_seq_gen import rubik_pkg::*; (
  input  wire logic       nvdla_core_clk,
  input  wire logic       rst_n,
  input  wire rubik_cfg_t cfg,
  input  wire logic       start,
  input  wire logic       lanes_free,
  input  wire logic       tile_done,
  input  wire logic       mem_rd_ready,
  output rd_req_t         rd_req,
  output logic            busy,
  output logic            done
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_READ,
    SEQ_WAIT,
    SEQ_DONE
  } seq_state_e;

  seq_state_e        state;
  logic [ADDR_W-1:0] rd_addr;   // next source word
  logic [IDX_W-1:0]  word_cnt;  // reads issued in this tile
  logic [TILE_W-1:0] tile_cnt;  // tiles written back
  logic              rd_vld;
  logic              rd_fire;

  assign rd_vld  = (state == SEQ_READ) && lanes_free;
  assign rd_fire = rd_vld && mem_rd_ready;

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      state    <= SEQ_IDLE;
      rd_addr  <= '0;
      word_cnt <= '0;
      tile_cnt <= '0;
    end else begin
      case (state)
        SEQ_IDLE, SEQ_DONE: begin
          state <= SEQ_IDLE;
          if (start) begin
            rd_addr  <= cfg.src;
            word_cnt <= '0;
            tile_cnt <= '0;
            state    <= (cfg.tiles == '0) ? SEQ_DONE : SEQ_READ;  // empty job finishes at once
          end
        end
        SEQ_READ: begin
          if (rd_fire) begin
            rd_addr  <= rd_addr + 1'b1;
            word_cnt <= word_cnt + 1'b1;  // wraps back to 0 for the next tile
            if (word_cnt == IDX_W'(LANES - 1)) begin
              state <= SEQ_WAIT;
            end
          end
        end
        SEQ_WAIT: begin
          if (tile_done) begin
            tile_cnt <= tile_cnt + 1'b1;
            if (tile_cnt + 1'b1 == cfg.tiles) begin
              state <= SEQ_DONE;
            end else begin
              state <= SEQ_READ;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  assign rd_req = '{valid: rd_vld, addr: rd_addr};
  assign busy   = (state == SEQ_READ) || (state == SEQ_WAIT);
  assign done   = (state == SEQ_DONE);  // one cycle after the last tile_done

endmodule

`default_nettype wire

// ==== hw/rubik_rsp_dist.sv ====
// read response feeder that registers and tags each word with its tile index for the lanes
`default_nettype none
`timescale 1ns/10ps

module rubik_rsp_dist import rubik_pkg::*; (
  input  wire logic    nvdla_core_clk,
  input  wire logic    rst_n,
  input  wire rd_rsp_t rd_rsp,
  input  wire logic    lanes_free,
  output lane_in_t     lane_in,
  output logic         tile_full
);

  logic              vld_q;
  logic [IDX_W-1:0]  tag_q;
  logic [WORD_W-1:0] data_q;
  logic [IDX_W-1:0]  idx;           // index of the next response
  logic              lanes_free_q;

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      vld_q        <= 1'b0;
      tag_q        <= '0;
      idx          <= '0;
      lanes_free_q <= 1'b1;
      tile_full    <= 1'b0;
    end else begin
      lanes_free_q <= lanes_free;
      vld_q        <= rd_rsp.valid;
      tag_q        <= idx;
      tile_full    <= vld_q && (tag_q == IDX_W'(LANES - 1));
      if (lanes_free && !lanes_free_q) begin
        idx <= '0;                   // resync on a fresh tile
      end else if (rd_rsp.valid) begin
        idx <= idx + 1'b1;           // wraps at LANES
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rd_rsp.valid) begin
      data_q <= rd_rsp.data;
    end
  end

  assign lane_in = '{valid: vld_q, idx: tag_q, data: data_q};

endmodule

`default_nettype wire

// ==== hw/rubik_lane.sv ====
// one lane buffer building a single output word of the tile from the broadcast input words
`default_nettype none
`timescale 1ns/10ps

module rubik_lane import rubik_pkg::*; #(
  parameter int LANE_ID = 0
) (
  input  wire logic        nvdla_core_clk,
  input  wire logic        rst_n,
  input  wire rubik_mode_e mode,
  input  wire lane_in_t    lane_in,
  output logic [WORD_W-1:0] word
);

  logic [ELEM_W-1:0] elem;  // this lane's element of the incoming word
  logic              own_word;

  assign elem     = lane_in.data[LANE_ID*ELEM_W +: ELEM_W];
  assign own_word = (lane_in.idx == IDX_W'(LANE_ID));

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      word <= '0;
    end else if (lane_in.valid) begin
      if (mode == MODE_TRANSPOSE) begin
        word[lane_in.idx*ELEM_W +: ELEM_W] <= elem;  // row r lands in element r
      end else if (own_word) begin
        word <= lane_in.data;  // straight copy
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/rubik_wr_pack.sv ====
// write drain that sends the lane words of a full tile to memory and then frees the lanes
`default_nettype none
`timescale 1ns/10ps

module rubik_wr_pack import rubik_pkg::*; (
  input  wire logic                         nvdla_core_clk,
  input  wire logic                         rst_n,
  input  wire rubik_cfg_t                   cfg,
  input  wire logic                         start,
  input  wire logic                         tile_full,
  input  wire logic [LANES-1:0][WORD_W-1:0] lane_words,
  input  wire logic                         mem_wr_ready,
  output wr_req_t                           wr_req,
  output logic                              lanes_free,
  output logic                              tile_done
);

  logic              draining;
  logic [IDX_W-1:0]  wsel;      // lane being written
  logic [ADDR_W-1:0] wr_addr;
  logic              wr_fire;

  assign wr_fire = draining && mem_wr_ready;

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      draining   <= 1'b0;
      wsel       <= '0;
      wr_addr    <= '0;
      lanes_free <= 1'b1;
      tile_done  <= 1'b0;
    end else begin
      tile_done <= 1'b0;
      if (start) begin
        wr_addr <= cfg.dst;
      end
      if (tile_full) begin
        draining   <= 1'b1;
        wsel       <= '0;
        lanes_free <= 1'b0;  // lanes hold an unwritten tile
      end
      if (wr_fire) begin
        wr_addr <= wr_addr + 1'b1;
        wsel    <= wsel + 1'b1;
        if (wsel == IDX_W'(LANES - 1)) begin
          draining   <= 1'b0;
          lanes_free <= 1'b1;
          tile_done  <= 1'b1;
        end
      end
    end
  end

  // held stable by the registers until the handshake
  assign wr_req = '{valid: draining, addr: wr_addr, data: lane_words[wsel]};

endmodule

`default_nettype wire

// ==== hw/rubik_top.sv ====
// top level of the tile transposer, wiring registers, sequencer, feeder, lanes and drain
`default_nettype none
`timescale 1ns/10ps

module rubik_top import rubik_pkg::*; (
  input  wire logic    nvdla_core_clk,
  input  wire logic    rst_n,
  input  wire wb_req_t wb_req,
  output wb_rsp_t      wb_rsp,
  output rd_req_t      rd_req,
  input  wire logic    mem_rd_ready,
  input  wire rd_rsp_t rd_rsp,
  output wr_req_t      wr_req,
  input  wire logic    mem_wr_ready,
  output logic         irq
);

  rubik_cfg_t                   cfg;
  logic                         start;
  logic                         busy;
  logic                         done;
  logic                         lanes_free;
  logic                         tile_done;
  logic                         tile_full;
  lane_in_t                     lane_in;
  logic [LANES-1:0][WORD_W-1:0] lane_words;

  rubik_regfile u_regfile (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .busy           (busy),
    .done           (done),
    .cfg            (cfg),
    .start          (start),
    .irq            (irq)
  );

  rubik_seq_gen u_seq_gen (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .cfg            (cfg),
    .start          (start),
    .lanes_free     (lanes_free),
    .tile_done      (tile_done),
    .mem_rd_ready   (mem_rd_ready),
    .rd_req         (rd_req),
    .busy           (busy),
    .done           (done)
  );

  rubik_rsp_dist u_rsp_dist (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .rd_rsp         (rd_rsp),
    .lanes_free     (lanes_free),
    .lane_in        (lane_in),
    .tile_full      (tile_full)
  );

  // one lane per output word
  for (genvar i = 0; i < LANES; i++) begin : gen_lane
    rubik_lane #(.LANE_ID(i)) u_lane (
      .nvdla_core_clk (nvdla_core_clk),
      .rst_n          (rst_n),
      .mode           (cfg.mode),
      .lane_in        (lane_in),
      .word           (lane_words[i])
    );
  end

  rubik_wr_pack u_wr_pack (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .cfg            (cfg),
    .start          (start),
    .tile_full      (tile_full),
    .lane_words     (lane_words),
    .mem_wr_ready   (mem_wr_ready),
    .wr_req         (wr_req),
    .lanes_free     (lanes_free),
    .tile_done      (tile_done)
  );

endmodule

`default_nettype wire

// ==== verification/rubik_chk.sv ====
// concurrent handshake checks on the Wishbone port and the memory ports, bound into the top level
`default_nettype none
`timescale 1ns/10ps

module rubik_chk import rubik_pkg::*; (
  input wire logic    nvdla_core_clk,
  input wire logic    rst_n,
  input wire wb_req_t wb_req,
  input wire wb_rsp_t wb_rsp,
  input wire rd_req_t rd_req,
  input wire wr_req_t wr_req,
  input wire logic    mem_wr_ready
);

  // ================================================
  // Wishbone classic
  // ================================================
  ack_follows_req: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
    else $error("wishbone ack missing one cycle after the request");

  ack_one_cycle: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("wishbone ack held longer than one cycle");

  // ================================================
  // memory ports
  // ================================================
  wr_held_stable: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    (wr_req.valid && !mem_wr_ready) |=> $stable(wr_req))
    else $error("write request changed under back-pressure");

  rd_not_during_wr: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    !(rd_req.valid && wr_req.valid))
    else $error("read request issued while a write is pending");

endmodule

bind rubik_top rubik_chk chk0 (
  .nvdla_core_clk (nvdla_core_clk),
  .rst_n          (rst_n),
  .wb_req         (wb_req),
  .wb_rsp         (wb_rsp),
  .rd_req         (rd_req),
  .wr_req         (wr_req),
  .mem_wr_ready   (mem_wr_ready)
);

`default_nettype wire

// ==== verification/rubik_tb.sv ====
// self-checking testbench for the tile transposer, built with Verilator from the file list
`default_nettype none
`timescale 1ns/10ps

module rubik_tb import rubik_pkg::*; ();

  localparam int MEM_WORDS   = 256;
  localparam int SEED        = 99;
  localparam int TOTAL_TILES = 10;    // tiles over all jobs
  localparam int TILE_NS     = 1800;  // generous bound per tile
  localparam int SETUP_NS    = 2000;  // reset and register traffic
  localparam int WATCHDOG_NS = TOTAL_TILES * TILE_NS + SETUP_NS;
  localparam logic [WORD_W-1:0] DONE_MASK = 32'd1 << STATUS_DONE_BIT;

  logic    nvdla_core_clk = 1'b0;
  logic    rst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  rd_req_t rd_req;
  logic    mem_rd_ready = 1'b0;
  rd_rsp_t rd_rsp = '0;
  wr_req_t wr_req;
  logic    mem_wr_ready = 1'b0;
  logic    irq;

  logic [WORD_W-1:0] mem   [MEM_WORDS];
  logic [WORD_W-1:0] image [MEM_WORDS];  // staged contents, copied in on load
  logic [WORD_W-1:0] rsp_data_q [$];
  int                rsp_due_q  [$];       // cycle at which each response is due
  int                cycle       = 0;
  logic [31:0]       mem_rng     = 32'(SEED);
  logic [31:0]       data_rng    = 32'(SEED);
  int                load_seq    = 0;
  int                load_seen   = 0;
  int                check_seq   = 0;
  int                check_seen  = 0;
  int                cmp_errors  = 0;
  int                write_count = 0;
  int                stray_count = 0;
  int                dst_lo      = 0;
  int                dst_hi      = 0;
  logic              wr_stall_en = 1'b0;
  rubik_mode_e       job_mode    = MODE_PASS;
  int                job_src     = 0;
  int                job_dst     = 0;
  int                job_tiles   = 0;
  int                test_errors  = 0;
  int                error_count  = 0;
  int                tests_run    = 0;
  int                tests_passed = 0;

  always #5 nvdla_core_clk = ~nvdla_core_clk;  // 10 ns period

  rubik_top dut0 (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .rd_req         (rd_req),
    .mem_rd_ready   (mem_rd_ready),
    .rd_rsp         (rd_rsp),
    .wr_req         (wr_req),
    .mem_wr_ready   (mem_wr_ready),
    .irq            (irq)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [WORD_W-1:0] background_word(input logic [7:0] a);
    return {a ^ 8'hc3, a, a ^ 8'h3c, ~a};
  endfunction

  // output word c takes element c of every input word r into element r
  function automatic logic [LANES-1:0][WORD_W-1:0] expected_tile(
    input rubik_mode_e                  mode,
    input logic [LANES-1:0][WORD_W-1:0] in_words
  );
    logic [LANES-1:0][WORD_W-1:0] out_words;
    out_words = in_words;
    if (mode == MODE_TRANSPOSE) begin
      for (int c = 0; c < LANES; c++) begin
        for (int r = 0; r < LANES; r++) begin
          out_words[IDX_W'(c)][r*ELEM_W +: ELEM_W] = in_words[IDX_W'(r)][c*ELEM_W +: ELEM_W];
        end
      end
    end
    return out_words;
  endfunction

  // ================================================
  // memory model
  // ================================================
  always @(negedge nvdla_core_clk) begin
    if (load_seen != load_seq) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        mem[8'(a)] = image[8'(a)];
      end
      write_count = 0;
      stray_count = 0;
      load_seen   = load_seq;
    end
    mem_rng = xorshift32(mem_rng);
    cycle   = cycle + 1;
    if (!rst_n) begin
      mem_rd_ready = 1'b0;
      mem_wr_ready = 1'b0;
      rd_rsp       = '0;
      rsp_data_q.delete();
      rsp_due_q.delete();
    end else begin
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin  // oldest first
        rd_rsp.valid = 1'b1;
        rd_rsp.data  = rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        rd_rsp.valid = 1'b0;
      end
      mem_rd_ready = mem_rng[0] | mem_rng[1];
      mem_wr_ready = wr_stall_en ? mem_rng[2] : 1'b1;
      if (rd_req.valid && mem_rd_ready) begin  // taken at the coming rising edge
        rsp_data_q.push_back(mem[rd_req.addr[7:0]]);
        rsp_due_q.push_back(cycle + 1 + int'(mem_rng[5:4]));
      end
      if (wr_req.valid && mem_wr_ready) begin
        write_count = write_count + 1;
        if (int'(wr_req.addr) < dst_lo || int'(wr_req.addr) >= dst_hi) begin
          stray_count = stray_count + 1;
        end else begin
          mem[wr_req.addr[7:0]] = wr_req.data;
        end
      end
    end
  end

  // compares the destination with the reference once a job has finished
  always @(negedge nvdla_core_clk) begin
    logic [LANES-1:0][WORD_W-1:0] src_tile;
    logic [LANES-1:0][WORD_W-1:0] exp_tile;
    int                           a;
    if (check_seen != check_seq) begin
      cmp_errors = 0;
      for (int t = 0; t < job_tiles; t++) begin
        for (int w = 0; w < LANES; w++) begin
          src_tile[IDX_W'(w)] = mem[8'(job_src + LANES * t + w)];
        end
        exp_tile = expected_tile(job_mode, src_tile);
        for (int w = 0; w < LANES; w++) begin
          a = job_dst + LANES * t + w;
          if (mem[8'(a)] !== exp_tile[IDX_W'(w)]) begin
            $display("[ERROR] %0d ns: mem[0x%02h] = 0x%08h, expected 0x%08h",
                     $time, a, mem[8'(a)], exp_tile[IDX_W'(w)]);
            cmp_errors = cmp_errors + 1;
          end
        end
      end
      if (write_count != LANES * job_tiles) begin
        $display("the job wrote %0d words instead of %0d", write_count, LANES * job_tiles);
        cmp_errors = cmp_errors + 1;
      end
      if (stray_count != 0) begin
        $display("%0d words were written outside the destination range", stray_count);
        cmp_errors = cmp_errors + 1;
      end
      check_seen = check_seq;
    end
  end

  // ================================================
  // bus and job tasks
  // ================================================
  task automatic write_reg(input logic [REG_ADDR_W-1:0] adr, input logic [WORD_W-1:0] dat);
    @(negedge nvdla_core_clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    @(negedge nvdla_core_clk);
    while (!wb_rsp.ack) @(negedge nvdla_core_clk);
    @(negedge nvdla_core_clk);  // cycle ends on the ack edge
    wb_req = '0;
  endtask

  task automatic read_reg(input logic [REG_ADDR_W-1:0] adr, output logic [WORD_W-1:0] dat);
    @(negedge nvdla_core_clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
    @(negedge nvdla_core_clk);
    while (!wb_rsp.ack) @(negedge nvdla_core_clk);
    dat = wb_rsp.dat;
    @(negedge nvdla_core_clk);
    wb_req = '0;
  endtask

  task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] adr,
                           input logic [WORD_W-1:0] exp);
    logic [WORD_W-1:0] got;
    read_reg(adr, got);
    if (got !== exp) begin
      $display("[ERROR] %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic stage_memory(input int src, input int words);
    for (int a = 0; a < MEM_WORDS; a++) begin
      image[8'(a)] = background_word(8'(a));
    end
    for (int w = 0; w < words; w++) begin
      data_rng = xorshift32(data_rng);
      image[8'(src + w)] = data_rng;
    end
  endtask

  task automatic load_memory();
    load_seq = load_seq + 1;
    while (load_seen != load_seq) @(negedge nvdla_core_clk);
  endtask

  task automatic run_job(input rubik_mode_e mode, input int src, input int dst, input int tiles);
    logic [WORD_W-1:0] ctrl;
    job_mode  = mode;
    job_src   = src;
    job_dst   = dst;
    job_tiles = tiles;
    dst_lo    = dst;
    dst_hi    = dst + LANES * tiles;
    write_reg(REG_SRC, 32'(src));
    write_reg(REG_DST, 32'(dst));
    write_reg(REG_TILES, 32'(tiles));
    ctrl = '0;
    ctrl[CTRL_MODE_BIT]  = mode;
    ctrl[CTRL_START_BIT] = 1'b1;
    write_reg(REG_CTRL, ctrl);
    while (!irq) @(negedge nvdla_core_clk);
    check_seq = check_seq + 1;
    while (check_seen != check_seq) @(negedge nvdla_core_clk);
    test_errors = test_errors + cmp_errors;
  endtask

  task automatic end_test(input int num, input string name);
    tests_run = tests_run + 1;
    if (test_errors == 0) begin
      tests_passed = tests_passed + 1;
      $display("test %0d %s: passed", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, test_errors);
    end
    error_count = error_count + test_errors;
    test_errors = 0;
  endtask

  // ================================================
  // test sequence
  // ================================================
  initial begin
    wb_req = '0;
    rst_n  = 1'b0;
    repeat (5) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    rst_n = 1'b1;

    check_reg("STATUS", REG_STATUS, '0);
    if (irq !== 1'b0) begin
      $display("irq is not low after reset");
      test_errors = test_errors + 1;
    end
    write_reg(REG_SRC, 32'h0000_1234);
    write_reg(REG_DST, 32'h0000_beef);
    write_reg(REG_TILES, 32'h0000_00a5);
    write_reg(REG_CTRL, 32'd1 << CTRL_MODE_BIT);  // mode only, no start
    check_reg("SRC", REG_SRC, 32'h0000_1234);
    check_reg("DST", REG_DST, 32'h0000_beef);
    check_reg("TILES", REG_TILES, 32'h0000_00a5);
    check_reg("CTRL", REG_CTRL, 32'd1 << CTRL_MODE_BIT);
    end_test(1, "register readback");

    stage_memory(0, 0);
    image[8'h10] = 32'h0302_0100;
    image[8'h11] = 32'h1312_1110;
    image[8'h12] = 32'h2322_2120;
    image[8'h13] = 32'h3332_3130;
    load_memory();
    run_job(MODE_TRANSPOSE, 'h10, 'h80, 1);
    write_reg(REG_STATUS, DONE_MASK);
    end_test(2, "transpose one tile");

    stage_memory('h20, 3 * LANES);
    load_memory();
    run_job(MODE_PASS, 'h20, 'h90, 3);
    write_reg(REG_STATUS, DONE_MASK);
    end_test(3, "pass three tiles");

    stage_memory('h40, 5 * LANES);
    load_memory();
    wr_stall_en = 1'b1;  // random write back-pressure
    run_job(MODE_TRANSPOSE, 'h40, 'ha0, 5);
    wr_stall_en = 1'b0;
    write_reg(REG_STATUS, DONE_MASK);
    end_test(4, "transpose five tiles under stalls");

    stage_memory('h10, LANES);
    load_memory();
    run_job(MODE_PASS, 'h10, 'hc0, 1);
    if (irq !== 1'b1) begin
      $display("irq did not stay high after the job");
      test_errors = test_errors + 1;
    end
    check_reg("STATUS", REG_STATUS, DONE_MASK);  // done set, busy low
    write_reg(REG_STATUS, DONE_MASK);
    if (irq !== 1'b0) begin
      $display("irq did not clear after writing the done bit");
      test_errors = test_errors + 1;
    end
    check_reg("STATUS", REG_STATUS, '0);
    end_test(5, "completion and clear");

    $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rubik_lite.f ====
hw/rubik_pkg.sv
hw/rubik_regfile.sv
hw/rubik_seq_gen.sv
hw/rubik_rsp_dist.sv
hw/rubik_lane.sv
hw/rubik_wr_pack.sv
hw/rubik_top.sv
verification/rubik_chk.sv
verification/rubik_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module rubik_top -f rubik_lite.f
	verilator --lint-only --timing --top-module rubik_tb -f rubik_lite.f

sim:
	verilator --binary --timing --assert --top-module rubik_tb -Mdir obj_dir -f rubik_lite.f
	@out="$$(./obj_dir/Vrubik_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
